//--- Bender.yml
package:
  name: fetch_top

sources:
  - include_dirs:
      - source
    files:
      - source/immu_pkg.sv
      - source/pc_sequencer.sv
      - source/immu.sv
      - source/fetch_queue.sv
      - source/mem_fetch_port.sv
      - source/fetch_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_fetch_top.sv

//--- source/fetch_queue.sv
`timescale 1ns/1ps

`include "immu_config.svh"

module fetch_queue #(
    parameter type payload_t = immu_pkg::fetch_req_t,
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input logic i_clk,
    input logic i_rst,

    input logic i_push,
    input payload_t i_data,

    input logic i_pop,
    output payload_t o_data,

    input logic i_flush,

    output logic o_full,
    output logic o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    assign o_full = (count == DEPTH);
    assign o_empty = (count == 0);
    assign o_data = mem[rd_ptr]; // head is visible before the pop

    assign do_push = i_push && !o_full && !i_flush;
    assign do_pop = i_pop && !o_empty && !i_flush;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // producer and consumer are expected to watch the levels
    assert property (@(posedge i_clk) disable iff (i_rst) i_push |-> !o_full)
        else $error("fetch_queue: push while full");
    assert property (@(posedge i_clk) disable iff (i_rst) i_pop |-> !o_empty)
        else $error("fetch_queue: pop while empty");

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

`include "immu_config.svh"

module fetch_top (
    input logic i_clk,
    input logic i_rst,

    input logic i_run,
    input logic i_long_mode,
    input logic i_pag_en,
    input immu_pkg::high_addr_t i_long_high_addr,

    input logic i_redirect,
    input immu_pkg::pc_t i_redirect_pc,

    input logic i_sr_we,
    input immu_pkg::sr_word_t i_sr_addr,
    input immu_pkg::sr_word_t i_sr_data,

    input logic i_mem_ready,

    output logic o_mem_rd,
    output immu_pkg::phys_addr_t o_mem_addr,
    output immu_pkg::pc_t o_mem_pc
);

    import immu_pkg::*;

    pc_t pc;
    logic issue;
    phys_addr_t phys_addr;
    logic full;
    logic empty;
    logic pop;
    fetch_req_t push_req;
    fetch_req_t head_req;

    assign push_req = '{addr: phys_addr, pc: pc};

    pc_sequencer u_pc_sequencer (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_run(i_run),
        .i_full(full),
        .i_redirect(i_redirect),
        .i_redirect_pc(i_redirect_pc),
        .o_pc(pc),
        .o_issue(issue)
    );

    immu u_immu (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_addr(pc),
        .o_addr(phys_addr),
        .i_sr_addr(i_sr_addr),
        .i_sr_data(i_sr_data),
        .i_sr_we(i_sr_we),
        .i_long_high_addr(i_long_high_addr),
        .i_long_mode(i_long_mode),
        .i_pag_en(i_pag_en)
    );

    fetch_queue #(
        .payload_t(fetch_req_t),
        .DEPTH(`FETCH_QUEUE_DEPTH)
    ) u_fetch_queue (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_push(issue),
        .i_data(push_req),
        .i_pop(pop),
        .o_data(head_req),
        .i_flush(i_redirect), // redirect drops everything queued
        .o_full(full),
        .o_empty(empty)
    );

    mem_fetch_port u_mem_fetch_port (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_empty(empty),
        .i_req_addr(head_req.addr),
        .i_req_pc(head_req.pc),
        .o_pop(pop),
        .i_mem_ready(i_mem_ready),
        .o_mem_rd(o_mem_rd),
        .o_mem_addr(o_mem_addr),
        .o_mem_pc(o_mem_pc)
    );

endmodule

//--- source/immu.sv
`timescale 1ns/1ps

`include "immu_config.svh"

module immu (
    input logic i_clk,
    input logic i_rst,

    input immu_pkg::pc_t i_addr,
    output immu_pkg::phys_addr_t o_addr,

    input immu_pkg::sr_word_t i_sr_addr,
    input immu_pkg::sr_word_t i_sr_data,
    input logic i_sr_we,

    input immu_pkg::high_addr_t i_long_high_addr,
    input logic i_long_mode,

    input logic i_pag_en
);

    import immu_pkg::*;

    logic [`OFF_W-1:0] page_off;
    logic [`PAGE_IDX_W-1:0] page_idx;
    page_entry_t page_table [`PAGE_ENTRIES];
    page_entry_t page_res;

    sr_word_t sr_idx;
    logic sr_in_range;
    logic sr_wr;

    phys_addr_t long_addr;
    phys_addr_t paged_addr;
    phys_addr_t unpaged_addr;

    assign page_off = i_addr[`OFF_W-1:0];
    assign page_idx = i_addr[`OFF_W+`PAGE_IDX_W-1:`OFF_W];

    //////////////////////////////////////////////////////////////////////
    // page table, written from special-register space
    //////////////////////////////////////////////////////////////////////

    assign sr_idx = i_sr_addr - `SR_ADDR_OFF;
    assign sr_in_range = (i_sr_addr >> `PAGE_IDX_W) == (`SR_ADDR_OFF >> `PAGE_IDX_W); // block decode
    assign sr_wr = i_sr_we && sr_in_range;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `PAGE_ENTRIES; i++) begin
                page_table[i] <= '0;
            end
            page_table[0] <= `PAGE_RES_SIZE'h7fe; // boot pages
            page_table[1] <= `PAGE_RES_SIZE'h7ff;
        end else if (sr_wr) begin
            page_table[sr_idx[`PAGE_IDX_W-1:0]] <= i_sr_data[`PAGE_RES_SIZE-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // translation
    //////////////////////////////////////////////////////////////////////

    assign page_res = {1'b1, page_table[page_idx][`PAGE_RES_SIZE-2:0]}; // top bit forced

    assign long_addr = {i_long_high_addr, i_addr};
    assign paged_addr = {page_res, page_off};
    assign unpaged_addr = {`PAGE_DEFAULT_PREFIX, i_addr};

    always_comb begin
        if (i_long_mode) begin
            o_addr = long_addr; // long mode wins over paging
        end else if (i_pag_en) begin
            o_addr = paged_addr;
        end else begin
            o_addr = unpaged_addr;
        end
    end

    // the range decode and the table size have to agree
    assert property (@(posedge i_clk) disable iff (i_rst)
        sr_wr |-> (sr_idx < `PAGE_ENTRIES))
        else $error("immu: page table write index %h out of range", sr_idx);

endmodule

//--- source/immu_config.svh
`ifndef IMMU_CONFIG_SVH
`define IMMU_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// address widths
//////////////////////////////////////////////////////////////////////

`define PC_ADDR_W 16 // fetch pc, steps by 2
`define OUT_ADDR_W 24 // physical fetch address
`define RW 16 // special-register addr/data width

//////////////////////////////////////////////////////////////////////
// page geometry
//////////////////////////////////////////////////////////////////////

`define OFF_W 12 // offset inside a page
`define PAGE_IDX_W 4 // pc bits 15:12 pick the entry
`define PAGE_ENTRIES 16
`define PAGE_RES_SIZE 12 // bit 11 is forced to 1 on lookup
`define SR_ADDR_OFF 16'h100 // page table base in sr space
`define PAGE_DEFAULT_PREFIX 8'h80 // unpaged, non-long mode prefix

`define FETCH_RESET_PC 16'h0000
`define FETCH_QUEUE_DEPTH 4

`endif

//--- source/immu_pkg.sv
`include "immu_config.svh"

package immu_pkg;

    // fetch side addresses
    typedef logic [`PC_ADDR_W-1:0] pc_t;
    typedef logic [`OUT_ADDR_W-1:0] phys_addr_t;
    typedef logic [`OUT_ADDR_W-`PC_ADDR_W-1:0] high_addr_t; // long mode upper byte

    // special-register bus word, used for both address and data
    typedef logic [`RW-1:0] sr_word_t;

    typedef logic [`PAGE_RES_SIZE-1:0] page_entry_t;

    // one translated fetch, as it sits in the queue
    typedef struct packed {
        phys_addr_t addr;
        pc_t pc;
    } fetch_req_t;

endpackage

//--- source/mem_fetch_port.sv
`timescale 1ns/1ps

module mem_fetch_port (
    input logic i_clk,
    input logic i_rst,

    input logic i_empty,
    input immu_pkg::phys_addr_t i_req_addr,
    input immu_pkg::pc_t i_req_pc,
    output logic o_pop,

    input logic i_mem_ready,

    output logic o_mem_rd,
    output immu_pkg::phys_addr_t o_mem_addr,
    output immu_pkg::pc_t o_mem_pc
);

    import immu_pkg::*;

    logic rd_q;
    phys_addr_t addr_q;
    pc_t pc_q;

    assign o_pop = !i_empty && i_mem_ready; // memory busy holds the queue

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= o_pop; // single cycle strobe per request
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            addr_q <= i_req_addr;
            pc_q <= i_req_pc;
        end
    end

    assign o_mem_rd = rd_q;
    assign o_mem_addr = addr_q;
    assign o_mem_pc = pc_q;

    //////////////////////////////////////////////////////////////////////
    // a read only follows a cycle where memory was ready
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge i_clk) disable iff (i_rst) !i_mem_ready |=> !o_mem_rd)
        else $error("mem_fetch_port: read strobe after busy cycle");

endmodule

//--- source/pc_sequencer.sv
`timescale 1ns/1ps

`include "immu_config.svh"

module pc_sequencer (
    input logic i_clk,
    input logic i_rst,

    input logic i_run,
    input logic i_full,

    input logic i_redirect,
    input immu_pkg::pc_t i_redirect_pc,

    output immu_pkg::pc_t o_pc,
    output logic o_issue
);

    import immu_pkg::*;

    pc_t pc_q;

    assign o_pc = pc_q;
    assign o_issue = i_run && !i_full && !i_redirect; // redirect cycle never issues

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (i_redirect) begin
            pc_q <= i_redirect_pc;
        end else if (o_issue) begin
            pc_q <= pc_q + pc_t'(2); // one instruction word
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // redirect targets must be word aligned as well
    assert property (@(posedge i_clk) disable iff (i_rst) o_pc[0] == 1'b0)
        else $error("pc_sequencer: odd fetch pc %h", o_pc);

endmodule

//--- tests/tb_fetch_top.sv
`timescale 1ns/1ps

`include "immu_config.svh"

module tb_fetch_top;

    import immu_pkg::*;

    logic i_clk;
    logic i_rst;
    logic i_run;
    logic i_long_mode;
    logic i_pag_en;
    high_addr_t i_long_high_addr;
    logic i_redirect;
    pc_t i_redirect_pc;
    logic i_sr_we;
    sr_word_t i_sr_addr;
    sr_word_t i_sr_data;
    logic i_mem_ready;
    logic o_mem_rd;
    phys_addr_t o_mem_addr;
    pc_t o_mem_pc;

    page_entry_t page_model [`PAGE_ENTRIES];
    pc_t exp_pc;
    phys_addr_t exp_addr;
    int read_count;
    bit run_seen;
    bit ready_random;

    fetch_top i_fetch_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    assign exp_addr = i_long_mode ? {i_long_high_addr, exp_pc} :
                      i_pag_en ? {1'b1, page_model[exp_pc[15:12]][10:0], exp_pc[11:0]} :
                      {`PAGE_DEFAULT_PREFIX, exp_pc};

    always @(posedge i_clk) begin
        if (i_rst) begin
            exp_pc <= `FETCH_RESET_PC;
            read_count <= 0;
        end else begin
            if (o_mem_rd) read_count <= read_count + 1;
            if (i_redirect) begin
                exp_pc <= i_redirect_pc;
            end else if (o_mem_rd) begin
                exp_pc <= exp_pc + 16'd2; // next instruction word
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    assert property (@(posedge i_clk) disable iff (i_rst) o_mem_rd |-> o_mem_pc == exp_pc)
        else abort_run($sformatf("ERROR: o_mem_pc = 0x%h, expected 0x%h",
                                 $sampled(o_mem_pc), $sampled(exp_pc)));
    assert property (@(posedge i_clk) disable iff (i_rst) o_mem_rd |-> o_mem_addr == exp_addr)
        else abort_run($sformatf("ERROR: o_mem_addr = 0x%h, expected 0x%h",
                                 $sampled(o_mem_addr), $sampled(exp_addr)));
    assert property (@(posedge i_clk) disable iff (i_rst) !run_seen |-> !o_mem_rd)
        else abort_run("a memory read was issued before fetching was started");

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic tick();
        @(negedge i_clk);
        i_mem_ready = ready_random ? (($urandom % 3) == 0) : 1'b1; // mostly busy when random
    endtask

    task automatic set_modes(input logic long_mode, input logic pag_en, input high_addr_t high);
        tick();
        i_long_mode = long_mode;
        i_pag_en = pag_en;
        i_long_high_addr = high;
    endtask

    task automatic sr_write(input sr_word_t addr, input sr_word_t data);
        tick();
        i_sr_we = 1'b1;
        i_sr_addr = addr;
        i_sr_data = data;
        if (addr >= `SR_ADDR_OFF && addr < `SR_ADDR_OFF + `PAGE_ENTRIES)
            page_model[addr - `SR_ADDR_OFF] = data[`PAGE_RES_SIZE-1:0];
        tick();
        i_sr_we = 1'b0;
    endtask

    task automatic redirect_to(input pc_t pc);
        tick();
        i_redirect = 1'b1;
        i_redirect_pc = pc;
        i_mem_ready = 1'b0; // keeps an old head out of the output register
        tick();
        i_redirect = 1'b0;
    endtask

    task automatic wait_reads(input int n);
        int target;
        int cycles;
        target = read_count + n;
        cycles = 0;
        while (read_count < target) begin
            tick();
            cycles++;
            if (cycles > 40 * n + 20)
                abort_run($sformatf("timed out waiting for %0d fetch reads", n));
        end
    endtask

    task automatic drain();
        int quiet;
        int cycles;
        quiet = 0;
        cycles = 0;
        tick();
        i_run = 1'b0;
        ready_random = 1'b0;
        while (quiet < 6) begin
            tick();
            quiet = o_mem_rd ? 0 : quiet + 1;
            cycles++;
            if (cycles > 100) abort_run("fetch queue did not drain after run was lowered");
        end
    endtask

    task automatic run_block(input pc_t start, input int n);
        redirect_to(start);
        tick();
        i_run = 1'b1;
        run_seen = 1'b1;
        wait_reads(n);
        drain();
    endtask

    initial begin
        void'($urandom(32'h98c08783));
        {i_rst, i_run, i_long_mode, i_pag_en, i_redirect, i_sr_we} = 6'b100000;
        i_long_high_addr = '0;
        i_redirect_pc = '0;
        i_sr_addr = '0;
        i_sr_data = '0;
        i_mem_ready = 1'b1;
        {run_seen, ready_random} = 2'b00;
        for (int i = 0; i < `PAGE_ENTRIES; i++) page_model[i] = '0;
        page_model[0] = 12'h7fe;
        page_model[1] = 12'h7ff;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        repeat (6) tick(); // idle, no reads yet

        tick();
        i_run = 1'b1; // unpaged from the reset pc
        run_seen = 1'b1;
        wait_reads(8);
        drain();

        set_modes(1'b0, 1'b1, 8'h00); // boot table
        run_block(16'h0ff8, 8);
        run_block(16'h1ff8, 8);

        sr_write(16'h0102, 16'h0123);
        sr_write(16'h0103, 16'hfabc); // bit 11 hidden by the forced bit
        sr_write(16'h010f, 16'h0456);
        sr_write(16'h00ff, 16'h0555); // both outside the table
        sr_write(16'h0110, 16'h0666);
        run_block(16'h2ff8, 8);
        run_block(16'hfff8, 8); // wraps into page 0

        set_modes(1'b1, 1'b1, 8'h5a);
        run_block(16'h3000, 6);
        set_modes(1'b1, 1'b0, 8'ha5);
        run_block(16'hc000, 6);

        set_modes(1'b0, 1'b0, 8'h00);
        ready_random = 1'b1;
        run_block(16'h4000, 40);

        set_modes(1'b0, 1'b1, 8'h00);
        ready_random = 1'b1;
        redirect_to(16'h1000);
        tick();
        i_run = 1'b1;
        wait_reads(5);
        redirect_to(16'h2800); // while the queue holds older pcs
        wait_reads(6);
        redirect_to(16'h1234);
        wait_reads(6);
        drain();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/immu_pkg.sv
source/pc_sequencer.sv
source/immu.sv
source/fetch_queue.sv
source/mem_fetch_port.sv
source/fetch_top.sv
tests/tb_fetch_top.sv
